/* src/latency_watch_pkg.sv */
`default_nettype none

package latency_watch_pkg;

	// *************************************************************************
	// Widths and defaults shared by the monitor blocks
	// *************************************************************************

	// One latency or statistic word
	localparam int unsigned COUNT_W = 12;
	// Slow threshold in cycles
	localparam int unsigned SLOW_LIMIT_DEF = 20;
	// History depth, a power of two
	localparam int unsigned HIST_DEPTH_DEF = 2;

	// Host read select
	typedef enum logic [1:0]
	{
		sel_max_latency = 2'd0,
		sel_slow_count = 2'd1,
		sel_hist_avg = 2'd2,
		sel_slow_flag = 2'd3
	} stat_sel_e;

	// Upper bits of a count kept per history entry
	// Bits above those needed to reach the limit, at least one
	function automatic int unsigned hist_bits(input int unsigned limit);
		int unsigned need;
		need = $clog2(limit + 1);
		if (need >= COUNT_W)
			return 1;
		return COUNT_W - need;
	endfunction

endpackage

`default_nettype wire

/* src/window_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface window_if
	import latency_watch_pkg::*;
();

	// Monitor enable from the top level
	logic enable;
	// One-cycle pulse, closes one interval and opens the next
	logic start;
	// Transaction waiting, req high and ack low
	logic busy;
	// Running count of the open interval
	logic [COUNT_W-1:0] count;

	// Tracker side
	modport src
	(
		output enable,
		output start,
		output busy
	);

	// Detector reads the strobes and owns the count
	modport det
	(
		input enable,
		input start,
		input busy,
		output count
	);

	// History samples the count at each start
	modport hist
	(
		input enable,
		input start,
		input count
	);

endinterface

`default_nettype wire

/* src/txn_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module txn_tracker
(
	input logic rvx_port_5,
	input logic rvx_port_0,
	input logic monitor_en,
	input logic bus_req,
	input logic bus_ack,
	window_if.src win
);

	// Previous sample of req
	logic req_q;
	// Registered strobes
	logic start_q;
	logic busy_q;

	// *************************************************************************
	// Bus tap
	// *************************************************************************

	// Only samples the channel, nothing is driven back
	always_ff @(posedge rvx_port_5, negedge rvx_port_0)
	begin
		if (!rvx_port_0)
		begin
			req_q <= 1'b0;
			start_q <= 1'b0;
			busy_q <= 1'b0;
		end
		else
		begin
			req_q <= bus_req;
			// Rising req marks a new transaction
			start_q <= bus_req && !req_q;
			// Waiting while req is up and no ack yet
			busy_q <= bus_req && !bus_ack;
		end
	end

	// Four-phase protocol keeps starts at least two cycles
	// apart after ack falls, so one pulse per transaction

	assign win.start = start_q;
	assign win.busy = busy_q;
	// Enable goes straight through to the window users
	assign win.enable = monitor_en;

endmodule

`default_nettype wire

/* src/latency_history.sv */
`timescale 1ns/10ps
`default_nettype none

module latency_history
	import latency_watch_pkg::*;
#(
	parameter int unsigned HIST_DEPTH = HIST_DEPTH_DEF,
	parameter int unsigned SLOW_LIMIT = SLOW_LIMIT_DEF
)
(
	input logic rvx_port_5,
	input logic rvx_port_0,
	window_if.hist win,
	output logic [COUNT_W-1:0] hist_avg
);

	// Kept bits per entry, same rule as the detector
	localparam int unsigned HIST_W = hist_bits(SLOW_LIMIT);
	// Divide by depth as a shift
	localparam int unsigned SHIFT = $clog2(HIST_DEPTH);
	// Sum never overflows
	localparam int unsigned SUM_W = HIST_W + SHIFT;

	logic [HIST_W-1:0] entry_q [HIST_DEPTH];
	logic [SUM_W-1:0] entry_sum;
	logic [HIST_W-1:0] avg_upper;
	logic [COUNT_W-1:0] avg_word;

	// *************************************************************************
	// Shift register of closed intervals
	// *************************************************************************

	always_ff @(posedge rvx_port_5, negedge rvx_port_0)
	begin
		if (!rvx_port_0)
		begin
			for (int i = 0; i < HIST_DEPTH; i++)
				entry_q[i] <= '0;
		end
		else if (win.enable && win.start)
		begin
			// Newest entry in slot 0, count still holds the closing value
			entry_q[0] <= win.count[COUNT_W-1 -: HIST_W];
			for (int i = 1; i < HIST_DEPTH; i++)
				entry_q[i] <= entry_q[i-1];
		end
	end

	// Sum of all entries
	always_comb
	begin
		entry_sum = '0;
		for (int i = 0; i < HIST_DEPTH; i++)
			entry_sum = entry_sum + SUM_W'(entry_q[i]);
	end

	assign avg_upper = HIST_W'(entry_sum >> SHIFT);

	// Back onto the count scale, low bits zero
	always_comb
	begin
		avg_word = '0;
		avg_word[COUNT_W-1 -: HIST_W] = avg_upper;
	end

	// Average follows the entries one cycle later
	always_ff @(posedge rvx_port_5, negedge rvx_port_0)
	begin
		if (!rvx_port_0)
			hist_avg <= '0;
		else
			hist_avg <= avg_word;
	end

endmodule

`default_nettype wire

/* src/slow_txn_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module slow_txn_detector
	import latency_watch_pkg::*;
#(
	parameter int unsigned SLOW_LIMIT = SLOW_LIMIT_DEF,
	parameter int unsigned RELATIVE = 0
)
(
	input logic rvx_port_5,
	input logic rvx_port_0,
	window_if.det win,
	input logic [COUNT_W-1:0] hist_avg,
	output logic [COUNT_W-1:0] max_latency,
	output logic [COUNT_W-1:0] slow_count,
	output logic slow_flag
);

	// Bits of the average that the history really holds
	localparam int unsigned HIST_W = hist_bits(SLOW_LIMIT);
	// Threshold on the count scale
	localparam logic [COUNT_W-1:0] LIMIT = COUNT_W'(SLOW_LIMIT);

	// Open interval count
	logic [COUNT_W-1:0] count_q;
	// Average with only the history bits
	logic [COUNT_W-1:0] avg_ref;
	// Enabled start, the close of an interval
	logic interval_close;
	// Flag set condition
	logic slow_set;

	assign interval_close = win.enable && win.start;
	assign win.count = count_q;

	// *************************************************************************
	// Interval counter
	// *************************************************************************

	always_ff @(posedge rvx_port_5, negedge rvx_port_0)
	begin
		if (!rvx_port_0)
			count_q <= '0;
		else if (win.enable)
		begin
			// New interval starts from zero
			if (win.start)
				count_q <= '0;
			// One per waiting cycle, saturating
			else if (win.busy && (count_q != '1))
				count_q <= count_q + 1'b1;
		end
	end

	// Worst case, taken from the count being closed
	always_ff @(posedge rvx_port_5, negedge rvx_port_0)
	begin
		if (!rvx_port_0)
			max_latency <= '0;
		else if (interval_close && (count_q > max_latency))
			max_latency <= count_q;
	end

	// *************************************************************************
	// Slow flag
	// *************************************************************************

	// Low bits of the history word ignored
	always_comb
	begin
		avg_ref = '0;
		avg_ref[COUNT_W-1 -: HIST_W] = hist_avg[COUNT_W-1 -: HIST_W];
	end

	always_comb
	begin
		slow_set = 1'b0;
		if (!slow_flag && (count_q >= LIMIT))
		begin
			// Absolute mode, the limit alone
			if (RELATIVE == 0)
				slow_set = 1'b1;
			// Relative mode, half the count must beat the average
			else if ((count_q >> 1) > avg_ref)
				slow_set = 1'b1;
		end
	end

	always_ff @(posedge rvx_port_5, negedge rvx_port_0)
	begin
		if (!rvx_port_0)
			slow_flag <= 1'b0;
		else if (win.enable)
		begin
			// Start wins over set
			if (win.start)
				slow_flag <= 1'b0;
			else if (slow_set)
				slow_flag <= 1'b1;
		end
	end

	// Slow intervals, counted as each one closes
	always_ff @(posedge rvx_port_5, negedge rvx_port_0)
	begin
		if (!rvx_port_0)
			slow_count <= '0;
		else if (interval_close && slow_flag && (slow_count != '1))
			slow_count <= slow_count + 1'b1;
	end

endmodule

`default_nettype wire

/* src/stat_readout.sv */
`timescale 1ns/10ps
`default_nettype none

module stat_readout
	import latency_watch_pkg::*;
(
	input logic rvx_port_5,
	input logic rvx_port_0,
	input logic rd_req,
	input stat_sel_e rd_sel,
	output logic rd_ack,
	output logic [COUNT_W-1:0] rd_data,
	input logic [COUNT_W-1:0] max_latency,
	input logic [COUNT_W-1:0] slow_count,
	input logic [COUNT_W-1:0] hist_avg,
	input logic slow_flag
);

	// Handshake states
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_capture = 2'd1;
	localparam logic [1:0] st_ack = 2'd2;
	localparam logic [1:0] st_release = 2'd3;

	logic [1:0] state_q;
	logic [1:0] state_d;
	// Statistic picked by rd_sel
	logic [COUNT_W-1:0] sel_value;

	// *************************************************************************
	// Four-phase FSM
	// *************************************************************************

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			// Wait for a fresh request, old ack fully gone
			st_idle:
				if (rd_req && !rd_ack)
					state_d = st_capture;
			// One cycle of delay before the ack
			st_capture:
				state_d = st_ack;
			// Hold until the host drops req
			st_ack:
				if (rd_ack && !rd_req)
					state_d = st_release;
			st_release:
				state_d = st_idle;
			default:
				state_d = st_idle;
		endcase
	end

	always_ff @(posedge rvx_port_5, negedge rvx_port_0)
	begin
		if (!rvx_port_0)
		begin
			state_q <= st_idle;
			rd_ack <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// Ack lags the state by a cycle on both edges
			rd_ack <= (state_q == st_ack) || (state_q == st_release);
		end
	end

	// Select mux
	always_comb
	begin
		case (rd_sel)
			sel_max_latency:
				sel_value = max_latency;
			sel_slow_count:
				sel_value = slow_count;
			sel_hist_avg:
				sel_value = hist_avg;
			sel_slow_flag:
				sel_value = COUNT_W'(slow_flag);
			default:
				sel_value = '0;
		endcase
	end

	// Snapshot taken together with the ack rise, stable until next read
	always_ff @(posedge rvx_port_5)
	begin
		if ((state_q == st_ack) && !rd_ack)
			rd_data <= sel_value;
	end

endmodule

`default_nettype wire

/* src/latency_watch.sv */
`timescale 1ns/10ps
`default_nettype none

module latency_watch
	import latency_watch_pkg::*;
#(
	parameter int unsigned SLOW_LIMIT = SLOW_LIMIT_DEF,
	parameter int unsigned HIST_DEPTH = HIST_DEPTH_DEF,
	parameter int unsigned RELATIVE = 0
)
(
	input logic rvx_port_5,
	input logic rvx_port_0,
	// Monitor on/off
	input logic monitor_en,
	// Tapped master/slave channel
	input logic bus_req,
	input logic bus_ack,
	// Host read port
	input logic rd_req,
	input stat_sel_e rd_sel,
	output logic rd_ack,
	output logic [COUNT_W-1:0] rd_data
);

	// Statistics toward the read port
	logic [COUNT_W-1:0] max_latency;
	logic [COUNT_W-1:0] slow_count;
	logic [COUNT_W-1:0] hist_avg;
	logic slow_flag;

	// *************************************************************************
	// Interval window shared by tracker, detector and history
	// *************************************************************************

	window_if win_i ();

	// Strobes from the tapped channel
	txn_tracker tracker_i
	(
		.rvx_port_5(rvx_port_5),
		.rvx_port_0(rvx_port_0),
		.monitor_en(monitor_en),
		.bus_req(bus_req),
		.bus_ack(bus_ack),
		.win(win_i.src)
	);

	// Counter, worst case and slow tracking
	slow_txn_detector
	#(
		.SLOW_LIMIT(SLOW_LIMIT),
		.RELATIVE(RELATIVE)
	)
	detector_i
	(
		.rvx_port_5(rvx_port_5),
		.rvx_port_0(rvx_port_0),
		.win(win_i.det),
		.hist_avg(hist_avg),
		.max_latency(max_latency),
		.slow_count(slow_count),
		.slow_flag(slow_flag)
	);

	// Recent latencies and their average
	latency_history
	#(
		.HIST_DEPTH(HIST_DEPTH),
		.SLOW_LIMIT(SLOW_LIMIT)
	)
	history_i
	(
		.rvx_port_5(rvx_port_5),
		.rvx_port_0(rvx_port_0),
		.win(win_i.hist),
		.hist_avg(hist_avg)
	);

	// *************************************************************************
	// Host side
	// *************************************************************************

	stat_readout readout_i
	(
		.rvx_port_5(rvx_port_5),
		.rvx_port_0(rvx_port_0),
		.rd_req(rd_req),
		.rd_sel(rd_sel),
		.rd_ack(rd_ack),
		.rd_data(rd_data),
		.max_latency(max_latency),
		.slow_count(slow_count),
		.hist_avg(hist_avg),
		.slow_flag(slow_flag)
	);

endmodule

`default_nettype wire

/* verif/latency_watch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module latency_watch_tb
	import latency_watch_pkg::*;
();

	// *************************************************************************
	// Bench constants
	// *************************************************************************

	localparam int unsigned HALF_PERIOD = 20;
	localparam int unsigned RESET_CYCLES = 10;
	// Falling edges allowed while waiting on rd_ack
	localparam int unsigned RD_TIMEOUT = 50;
	localparam int unsigned TXN_COUNT = 200;
	localparam int unsigned IDLE_TXN_COUNT = 30;
	localparam int unsigned RESUME_TXN_COUNT = 40;
	// History entry drops the bits that just reach the limit
	localparam int unsigned LOW_BITS = $clog2(SLOW_LIMIT_DEF + 1);
	// Falling edges from driving rd_req to seeing rd_ack move
	// One edge for the DUT to see req, two for the ack, then the sample
	localparam int unsigned ACK_DELAY = 4;

	logic rvx_port_5;
	logic rvx_port_0;
	logic monitor_en;
	logic bus_req;
	logic bus_ack;
	logic rd_req;
	stat_sel_e rd_sel;
	logic rd_ack;
	logic [COUNT_W-1:0] rd_data;

	logic [31:0] rng_state;
	int unsigned test_num;
	int unsigned test_errors;
	int unsigned tests_passed;
	int unsigned tests_failed;

	// Reference model of the monitor
	logic req_seen;
	logic [COUNT_W-1:0] open_count;
	logic [COUNT_W-1:0] model_max;
	logic [COUNT_W-1:0] model_slow;
	// Upper bits of the two newest closed intervals
	logic [COUNT_W-1:0] hist_new;
	logic [COUNT_W-1:0] hist_old;

	latency_watch
	#(
		.RELATIVE(1)
	)
	dut_i
	(
		.rvx_port_5(rvx_port_5),
		.rvx_port_0(rvx_port_0),
		.monitor_en(monitor_en),
		.bus_req(bus_req),
		.bus_ack(bus_ack),
		.rd_req(rd_req),
		.rd_sel(rd_sel),
		.rd_ack(rd_ack),
		.rd_data(rd_data)
	);

	always #HALF_PERIOD rvx_port_5 = ~rvx_port_5;

	// *************************************************************************
	// Model
	// *************************************************************************

	// LCG step, value below bound
	function automatic int unsigned next_random(input int unsigned bound);
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return (rng_state >> 8) % bound;
	endfunction

	// Mean of the entries, put back on the count scale
	function automatic logic [COUNT_W-1:0] model_avg();
		return ((hist_new + hist_old) >> 1) << LOW_BITS;
	endfunction

	// Limit reached and half the count above the average
	function automatic logic is_slow(input logic [COUNT_W-1:0] cnt);
		return (cnt >= COUNT_W'(SLOW_LIMIT_DEF)) && ((cnt >> 1) > model_avg());
	endfunction

	function automatic void close_interval();
		if (open_count > model_max)
			model_max = open_count;
		// Slow is judged against the history before this push
		if (is_slow(open_count))
			model_slow = model_slow + COUNT_W'(1);
		hist_old = hist_new;
		hist_new = open_count >> LOW_BITS;
		open_count = '0;
	endfunction

	function automatic logic [COUNT_W-1:0] expected_stat(input stat_sel_e sel);
		case (sel)
			sel_max_latency:
				return model_max;
			sel_slow_count:
				return model_slow;
			sel_hist_avg:
				return model_avg();
			default:
				return COUNT_W'(is_slow(open_count));
		endcase
	endfunction

	// Samples the channel on the same edges as the DUT
	always @(posedge rvx_port_5 or negedge rvx_port_0)
	begin
		if (!rvx_port_0)
		begin
			req_seen = 1'b0;
			open_count = '0;
			model_max = '0;
			model_slow = '0;
			hist_new = '0;
			hist_old = '0;
		end
		else
		begin
			if (monitor_en)
			begin
				// Start edge closes the old interval and is not counted itself
				if (bus_req && !req_seen)
					close_interval();
				else if (bus_req && !bus_ack)
					open_count = open_count + COUNT_W'(1);
			end
			req_seen = bus_req;
		end
	end

	// *************************************************************************
	// Stimulus and checks
	// *************************************************************************

	task automatic check_value(input string name, input logic [COUNT_W-1:0] got,
		input logic [COUNT_W-1:0] exp);
		assert (got === exp)
		else
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string title);
		test_num++;
		if (test_errors == 0)
		begin
			$display("test %0d %s: ok", test_num, title);
			tests_passed++;
		end
		else
		begin
			$display("test %0d %s: %0d errors", test_num, title, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	// Master raises req, slave acks after the wait, then both drop
	task automatic run_txn(input int unsigned wait_cycles, input int unsigned gap);
		@(posedge rvx_port_5);
		bus_req <= 1'b1;
		repeat (wait_cycles) @(posedge rvx_port_5);
		bus_ack <= 1'b1;
		@(posedge rvx_port_5);
		bus_req <= 1'b0;
		@(posedge rvx_port_5);
		bus_ack <= 1'b0;
		repeat (gap) @(posedge rvx_port_5);
	endtask

	task automatic random_txns(input int unsigned n);
		int unsigned k;
		for (k = 0; k < n; k++)
			run_txn(next_random(61), 3 + next_random(6));
	endtask

	// Full four-phase read, timing checked on both ack edges
	task automatic read_stat(input stat_sel_e sel, input int unsigned hold,
		output logic [COUNT_W-1:0] data);
		int unsigned edges;
		logic ack_now;
		logic rose;
		@(posedge rvx_port_5);
		rd_sel <= sel;
		rd_req <= 1'b1;
		edges = 0;
		ack_now = 1'b0;
		while (!ack_now && (edges < RD_TIMEOUT))
		begin
			@(negedge rvx_port_5);
			edges++;
			ack_now = rd_ack;
		end
		rose = ack_now;
		data = rd_data;
		if (!rose)
		begin
			$display("timeout: rd_ack never rose on a %s read", sel.name());
			test_errors++;
		end
		else
			assert (edges == ACK_DELAY)
			else
			begin
				$display("error: rd_ack rise delay %0h expected %0h", edges, ACK_DELAY);
				test_errors++;
			end
		// Host holds req, ack stays up and the snapshot must not move
		repeat (hold)
		begin
			@(negedge rvx_port_5);
			check_value("rd_ack", COUNT_W'(rd_ack), COUNT_W'(1'b1));
			check_value("rd_data", rd_data, data);
		end
		@(posedge rvx_port_5);
		rd_req <= 1'b0;
		edges = 0;
		while (ack_now && (edges < RD_TIMEOUT))
		begin
			@(negedge rvx_port_5);
			edges++;
			ack_now = rd_ack;
		end
		if (ack_now)
		begin
			$display("timeout: rd_ack stayed high after rd_req fell");
			test_errors++;
		end
		else if (rose)
			assert (edges == ACK_DELAY)
			else
			begin
				$display("error: rd_ack fall delay %0h expected %0h", edges, ACK_DELAY);
				test_errors++;
			end
	endtask

	task automatic read_check(input stat_sel_e sel);
		logic [COUNT_W-1:0] data;
		read_stat(sel, 0, data);
		check_value(sel.name(), data, expected_stat(sel));
	endtask

	initial
	begin
		logic [COUNT_W-1:0] data;
		logic [COUNT_W-1:0] frozen [4];
		int unsigned i;
		stat_sel_e sel;
		rng_state = 32'h1108_1b13;
		test_num = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		rvx_port_5 = 1'b0;
		rvx_port_0 = 1'b0;
		monitor_en = 1'b1;
		bus_req = 1'b0;
		bus_ack = 1'b0;
		rd_req = 1'b0;
		rd_sel = sel_max_latency;
		repeat (RESET_CYCLES) @(posedge rvx_port_5);
		rvx_port_0 <= 1'b1;

		// Reset values, no ack before any request
		@(negedge rvx_port_5);
		check_value("rd_ack", COUNT_W'(rd_ack), '0);
		for (i = 0; i < 4; i++)
		begin
			sel = stat_sel_e'(i[1:0]);
			read_stat(sel, 0, data);
			check_value(sel.name(), data, '0);
		end
		finish_test("reset values");

		random_txns(TXN_COUNT);
		read_check(sel_max_latency);
		finish_test("worst-case latency");
		read_check(sel_slow_count);
		read_check(sel_slow_flag);
		finish_test("slow interval count");
		read_check(sel_hist_avg);
		finish_test("history average");

		// Monitor off, everything frozen, then resume
		for (i = 0; i < 4; i++)
			read_stat(stat_sel_e'(i[1:0]), 0, frozen[i]);
		@(posedge rvx_port_5);
		monitor_en <= 1'b0;
		random_txns(IDLE_TXN_COUNT);
		for (i = 0; i < 4; i++)
		begin
			sel = stat_sel_e'(i[1:0]);
			read_stat(sel, 0, data);
			check_value(sel.name(), data, frozen[i]);
			check_value(sel.name(), data, expected_stat(sel));
		end
		@(posedge rvx_port_5);
		monitor_en <= 1'b1;
		random_txns(RESUME_TXN_COUNT);
		for (i = 0; i < 4; i++)
			read_check(stat_sel_e'(i[1:0]));
		finish_test("disabled monitor");

		// Long hold on the read port
		read_stat(sel_max_latency, 5 + next_random(11), data);
		check_value("sel_max_latency", data, model_max);
		finish_test("read handshake");

		$display("summary: %0d passed, %0d with errors", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* latency_watch.f */
src/latency_watch_pkg.sv
src/window_if.sv
src/txn_tracker.sv
src/latency_history.sv
src/slow_txn_detector.sv
src/stat_readout.sv
src/latency_watch.sv
verif/latency_watch_tb.sv

/* Makefile */
# Verilator build and run for the latency monitor testbench

VERILATOR := verilator
TOP := latency_watch_tb
FILELIST := latency_watch.f
OBJ_DIR := obj_dir
VFLAGS := --binary --timing --assert -j 0 -Mdir $(OBJ_DIR)
PASS_MSG := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Status comes from the pass-message search
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
